//--- include/host_cfg.svh
`ifndef HOST_CFG_SVH
`define HOST_CFG_SVH

// Host bus widths
`define HOST_AW 16
`define HOST_DW 32
`define HOST_SW 4

// Boot key width
`define KEY_W 128

// L2 scratchpad geometry, word interleaved
`define L2_NUM_BANKS 4
`define L2_BANK_WORDS 64

// Address map, byte addresses
`define L2_BASE 16'h0000
`define CTRL_BASE 16'h1000
`define CTRL_BYTES 32

`endif

//--- hw/host_pkg.sv
`default_nettype none

`include "host_cfg.svh"

package host_pkg;

  // Wishbone classic request, master to target
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`HOST_AW-1:0]    adr;
    logic [`HOST_DW-1:0]    dat;
    logic [`HOST_SW-1:0]    sel;
  } wb_req_t;

  // Wishbone classic response, target to master
  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`HOST_DW-1:0]    dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CTRL,
    TGT_NONE
  } host_tgt_e;

  // Byte offsets inside the control block
  typedef enum logic [4:0] {
    REG_CLUSTER_CTRL = 5'h00,
    REG_GWT_CFG      = 5'h04,
    REG_KEY0         = 5'h10,
    REG_KEY1         = 5'h14,
    REG_KEY2         = 5'h18,
    REG_KEY3         = 5'h1C
  } ctrl_reg_e;

endpackage

`default_nettype wire

//--- hw/host_bus_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_bus_router
  import host_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire wb_req_t mst_req_i,
  output wb_rsp_t      mst_rsp_o,
  output wb_req_t      l2_req_o,
  input  wire wb_rsp_t l2_rsp_i,
  output wb_req_t      ctrl_req_o,
  input  wire wb_rsp_t ctrl_rsp_i
);

  localparam int unsigned L2_BYTES   = `L2_NUM_BANKS * `L2_BANK_WORDS * (`HOST_DW / 8);
  localparam int unsigned CTRL_BYTES = `CTRL_BYTES;

  logic [`HOST_AW-1:0] l2_off;
  logic [`HOST_AW-1:0] ctrl_off;
  host_tgt_e           tgt;
  logic                err_q;

  // Region-relative offsets, out of range values wrap high
  assign l2_off   = mst_req_i.adr - `L2_BASE;
  assign ctrl_off = mst_req_i.adr - `CTRL_BASE;

  always_comb begin
    if (32'(l2_off) < L2_BYTES) begin
      tgt = TGT_L2;
    end else if (32'(ctrl_off) < CTRL_BYTES) begin
      tgt = TGT_CTRL;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Steer stb and hand each target its own offset
  always_comb begin
    l2_req_o       = mst_req_i;
    l2_req_o.stb   = mst_req_i.stb && (tgt == TGT_L2);
    l2_req_o.adr   = l2_off;
    ctrl_req_o     = mst_req_i;
    ctrl_req_o.stb = mst_req_i.stb && (tgt == TGT_CTRL);
    ctrl_req_o.adr = ctrl_off;
  end

  // Unmapped access answers with a single err pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= mst_req_i.cyc && mst_req_i.stb && (tgt == TGT_NONE) && !err_q;
    end
  end

  always_comb begin
    mst_rsp_o.ack = l2_rsp_i.ack | ctrl_rsp_i.ack;
    mst_rsp_o.err = err_q | l2_rsp_i.err | ctrl_rsp_i.err;
    // Address is still held while the response is out
    case (tgt)
      TGT_L2:   mst_rsp_o.dat = l2_rsp_i.dat;
      TGT_CTRL: mst_rsp_o.dat = ctrl_rsp_i.dat;
      default:  mst_rsp_o.dat = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/l2_banks.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module l2_banks
  import host_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire wb_req_t req_i,
  output wb_rsp_t      rsp_o
);

  localparam int BANK_BITS = $clog2(`L2_NUM_BANKS);
  localparam int IDX_BITS  = $clog2(`L2_BANK_WORDS);

  logic [BANK_BITS-1:0] bank_sel;
  logic [IDX_BITS-1:0]  bank_idx;
  logic                 access;
  logic                 ack_q;
  logic [BANK_BITS-1:0] bank_q;
  logic [`HOST_DW-1:0]  bank_rdata [`L2_NUM_BANKS];

  // Low word bits pick the bank, the rest index inside it
  assign bank_sel = req_i.adr[2 +: BANK_BITS];
  assign bank_idx = req_i.adr[2 + BANK_BITS +: IDX_BITS];

  // No new access while the previous ack is out
  assign access = req_i.cyc && req_i.stb && !ack_q;

  for (genvar b = 0; b < `L2_NUM_BANKS; b++) begin : g_bank
    logic [`HOST_DW-1:0] mem_q [`L2_BANK_WORDS];
    logic [`HOST_DW-1:0] rdata_q;
    logic                bank_en;

    assign bank_en = access && (bank_sel == BANK_BITS'(b));

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (req_i.we) begin
          for (int i = 0; i < `HOST_SW; i++) begin
            if (req_i.sel[i]) begin
              mem_q[bank_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
            end
          end
        end
        rdata_q <= mem_q[bank_idx];
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      bank_q <= bank_sel;
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
    rsp_o.dat = bank_rdata[bank_q];
  end

endmodule

`default_nettype wire

//--- hw/host_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_ctrl_regs
  import host_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire wb_req_t         req_i,
  output wb_rsp_t              rsp_o,
  output logic [`KEY_W-1:0]    key_o,
  output logic [`HOST_DW-1:0]  gwt_cfg_o,
  output logic                 cluster_fetch_en_o,
  output logic                 cluster_en_sa_boot_o
);

  ctrl_reg_e           reg_sel;
  logic                access;
  logic                ack_q;
  logic [`HOST_DW-1:0] rdata_q;
  logic [`HOST_DW-1:0] rdata;
  logic [1:0]          cl_ctrl_q;
  logic [`HOST_DW-1:0] gwt_cfg_q;
  logic [`KEY_W-1:0]   key_q;

  assign reg_sel = ctrl_reg_e'(req_i.adr[4:0]);
  assign access  = req_i.cyc && req_i.stb && !ack_q;

  // Unknown offsets read as zero
  always_comb begin
    case (reg_sel)
      REG_CLUSTER_CTRL: rdata = {{(`HOST_DW-2){1'b0}}, cl_ctrl_q};
      REG_GWT_CFG:      rdata = gwt_cfg_q;
      REG_KEY0:         rdata = key_q[31:0];
      REG_KEY1:         rdata = key_q[63:32];
      REG_KEY2:         rdata = key_q[95:64];
      REG_KEY3:         rdata = key_q[127:96];
      default:          rdata = '0;
    endcase
  end

  // Whole-word writes, sel ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      cl_ctrl_q <= '0;
      gwt_cfg_q <= '0;
      key_q     <= '0;
    end else begin
      ack_q <= access;
      if (access && req_i.we) begin
        case (reg_sel)
          REG_CLUSTER_CTRL: cl_ctrl_q      <= req_i.dat[1:0];
          REG_GWT_CFG:      gwt_cfg_q      <= req_i.dat;
          REG_KEY0:         key_q[31:0]    <= req_i.dat;
          REG_KEY1:         key_q[63:32]   <= req_i.dat;
          REG_KEY2:         key_q[95:64]   <= req_i.dat;
          REG_KEY3:         key_q[127:96]  <= req_i.dat;
          default:          ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata;
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
    rsp_o.dat = rdata_q;
  end

  assign key_o                = key_q;
  assign gwt_cfg_o            = gwt_cfg_q;
  // Bit 0 fetch enable, bit 1 standalone boot
  assign cluster_fetch_en_o   = cl_ctrl_q[0];
  assign cluster_en_sa_boot_o = cl_ctrl_q[1];

endmodule

`default_nettype wire

//--- hw/host_domain.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_domain
  import host_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire wb_req_t            wb_req_i,
  output wb_rsp_t                 wb_rsp_o,
  output logic [`KEY_W-1:0]       key_o,
  output logic [`HOST_DW-1:0]     gwt_cfg_o,
  output logic                    cluster_fetch_en_o,
  output logic                    cluster_en_sa_boot_o
);

  wb_req_t l2_req;
  wb_rsp_t l2_rsp;
  wb_req_t ctrl_req;
  wb_rsp_t ctrl_rsp;

  host_bus_router u_router (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .mst_req_i  ( wb_req_i ),
    .mst_rsp_o  ( wb_rsp_o ),
    .l2_req_o   ( l2_req   ),
    .l2_rsp_i   ( l2_rsp   ),
    .ctrl_req_o ( ctrl_req ),
    .ctrl_rsp_i ( ctrl_rsp )
  );

  // Banked scratchpad
  l2_banks u_l2 (
    .clk_i ( clk_i  ),
    .rst_i ( rst_i  ),
    .req_i ( l2_req ),
    .rsp_o ( l2_rsp )
  );

  // Key, watchdog and cluster boot controls
  host_ctrl_regs u_ctrl (
    .clk_i                ( clk_i                ),
    .rst_i                ( rst_i                ),
    .req_i                ( ctrl_req             ),
    .rsp_o                ( ctrl_rsp             ),
    .key_o                ( key_o                ),
    .gwt_cfg_o            ( gwt_cfg_o            ),
    .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
    .cluster_en_sa_boot_o ( cluster_en_sa_boot_o )
  );

endmodule

`default_nettype wire

//--- sim/host_domain_checker.sv
`timescale 1ns/1ps
`default_nettype none

module host_domain_checker
  import host_pkg::*;
(
  input wire logic    clk_i,
  input wire logic    rst_i,
  input wire wb_req_t req_i,
  input wire wb_rsp_t rsp_i
);

  logic rsp;

  assign rsp = rsp_i.ack || rsp_i.err;

  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rsp_i.ack && rsp_i.err))
    else $error("ack and err are high together");

  rsp_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp |-> (req_i.cyc && req_i.stb))
    else $error("Response seen without an active strobe");

  // Single-cycle latency from a fresh strobe
  rsp_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(req_i.stb) |=> rsp)
    else $error("No response one cycle after a new strobe");

  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i.stb && !rsp) |=> ($stable(req_i.adr) && $stable(req_i.we) &&
                             $stable(req_i.dat) && $stable(req_i.sel)))
    else $error("Request fields changed while waiting for a response");

endmodule

bind host_domain host_domain_checker u_checker (
  .clk_i ( clk_i    ),
  .rst_i ( rst_i    ),
  .req_i ( wb_req_i ),
  .rsp_i ( wb_rsp_o )
);

`default_nettype wire

//--- sim/tb_host_domain.sv
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module tb_host_domain
  import host_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_N       = 64;
  localparam int XFER_CYCLES  = 10;
  localparam int MAX_LINES    = 128;
  localparam int AW           = `HOST_AW;
  localparam int L2_WORDS     = `L2_NUM_BANKS * `L2_BANK_WORDS;

  logic                clk_i;
  logic                rst_i;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  logic [`KEY_W-1:0]   key;
  logic [`HOST_DW-1:0] gwt_cfg;
  logic                fetch_en;
  logic                sa_boot;

  // One entry per stimulus line
  logic                st_we  [MAX_LINES];
  logic [AW-1:0]       st_adr [MAX_LINES];
  logic [`HOST_DW-1:0] st_dat [MAX_LINES];
  logic [`HOST_SW-1:0] st_sel [MAX_LINES];
  logic [`HOST_DW-1:0] st_exp [MAX_LINES];
  logic                st_err [MAX_LINES];
  int                  n_lines = 0;
  bit                  loaded = 1'b0;
  int                  seed = 48112;

  // Reference state for L2 and the control block
  logic [`HOST_DW-1:0] shadow [L2_WORDS];
  bit                  known [L2_WORDS];
  int                  written [$];
  logic [`KEY_W-1:0]   key_exp = '0;
  logic [`HOST_DW-1:0] gwt_exp = '0;
  logic [1:0]          cl_exp = '0;

  host_domain u_dut (
    .clk_i                ( clk_i    ),
    .rst_i                ( rst_i    ),
    .wb_req_i             ( wb_req   ),
    .wb_rsp_o             ( wb_rsp   ),
    .key_o                ( key      ),
    .gwt_cfg_o            ( gwt_cfg  ),
    .cluster_fetch_en_o   ( fetch_en ),
    .cluster_en_sa_boot_o ( sa_boot  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  function automatic logic [`HOST_DW-1:0] merge_bytes(input logic [`HOST_DW-1:0] old_word,
      input logic [`HOST_DW-1:0] new_word, input logic [`HOST_SW-1:0] sel);
    logic [`HOST_DW-1:0] word;
    word = old_word;
    for (int b = 0; b < `HOST_SW; b++) begin
      if (sel[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // Whole-word register writes, key word 0 in the low bits
  task automatic model_ctrl_write(input logic [AW-1:0] adr, input logic [`HOST_DW-1:0] dat);
    case (adr)
      `CTRL_BASE + 16'h00: cl_exp = dat[1:0];
      `CTRL_BASE + 16'h04: gwt_exp = dat;
      `CTRL_BASE + 16'h10: key_exp[31:0] = dat;
      `CTRL_BASE + 16'h14: key_exp[63:32] = dat;
      `CTRL_BASE + 16'h18: key_exp[95:64] = dat;
      `CTRL_BASE + 16'h1C: key_exp[127:96] = dat;
      default: ;
    endcase
  endtask

  task automatic check_outputs();
    assert (key == key_exp && gwt_cfg == gwt_exp)
      else abort_run($sformatf("Mismatch at %0t: key_o %h gwt_cfg_o %h, expected %h %h",
                               $time, key, gwt_cfg, key_exp, gwt_exp));
    assert (fetch_en == cl_exp[0] && sa_boot == cl_exp[1])
      else abort_run($sformatf("Mismatch at %0t: cluster outputs %b%b, expected %b",
                               $time, sa_boot, fetch_en, cl_exp));
  endtask

  task automatic bus_xfer(input logic we, input logic [AW-1:0] adr,
                          input logic [`HOST_DW-1:0] dat, input logic [`HOST_SW-1:0] sel,
                          output logic [`HOST_DW-1:0] rdata, output logic err);
    wb_req_t req;
    int      edges;
    req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    edges = 0;
    @(posedge clk_i);
    wb_req <= req;
    // Sample mid-cycle, away from the active edge
    @(negedge clk_i);
    while (!wb_rsp.ack && !wb_rsp.err) begin
      edges++;
      @(negedge clk_i);
    end
    assert (edges == 1)
      else abort_run($sformatf("Mismatch at %0t: response at %h after %0d cycles, expected 1",
                               $time, adr, edges));
    rdata = wb_rsp.dat;
    err   = wb_rsp.err;
    @(posedge clk_i);
    wb_req <= '0;
  endtask

  task automatic load_stimulus();
    int                  fd;
    int                  c;
    int                  code;
    logic [AW-1:0]       adr;
    logic [`HOST_DW-1:0] dat;
    logic [`HOST_SW-1:0] sel;
    logic [`HOST_DW-1:0] exp_dat;
    logic                exp_err;
    fd = $fopen("sim/host_stim.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file sim/host_stim.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (8'(c) == "#") begin
        while (c != -1 && 8'(c) != "\n") begin
          c = $fgetc(fd);
        end
      end else if (8'(c) == "W" || 8'(c) == "R") begin
        code = $fscanf(fd, " %h %h %h %h %h", adr, dat, sel, exp_dat, exp_err);
        if (code != 5 || n_lines == MAX_LINES) begin
          abort_run("Stimulus file has a malformed line or too many lines");
        end
        st_we[n_lines]  = (8'(c) == "W");
        st_adr[n_lines] = adr;
        st_dat[n_lines] = dat;
        st_sel[n_lines] = sel;
        st_exp[n_lines] = exp_dat;
        st_err[n_lines] = exp_err;
        n_lines++;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // Ten cycles per transaction plus the reset phase
  initial begin
    wait (loaded);
    #((n_lines + RAND_N) * XFER_CYCLES * CLK_PERIOD + (RESET_CYCLES + 1) * CLK_PERIOD);
    abort_run("Timeout: the test did not reach its end in time");
  end

  initial begin
    logic [`HOST_DW-1:0] rdata;
    logic                err;
    logic [`HOST_DW-1:0] dat;
    logic [`HOST_SW-1:0] sel;
    logic [31:0]         r;
    int                  idx;
    rst_i  = 1'b1;
    wb_req = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (!wb_rsp.ack && !wb_rsp.err)
      else abort_run("Bus response is active right after reset");
    check_outputs();

    for (int i = 0; i < n_lines; i++) begin
      bus_xfer(st_we[i], st_adr[i], st_dat[i], st_sel[i], rdata, err);
      if (st_we[i]) begin
        model_ctrl_write(st_adr[i], st_dat[i]);
      end
      assert (err == st_err[i] && (st_we[i] || rdata == st_exp[i]))
        else abort_run($sformatf("Mismatch at %0t: entry %0d at %h gave %h err %b, expected %h %b",
                                 $time, i, st_adr[i], rdata, err, st_exp[i], st_err[i]));
      check_outputs();
    end

    // Random L2 traffic
    for (int i = 0; i < RAND_N; i++) begin
      r = $random(seed);
      if (r[0] || written.size() == 0) begin
        idx = {$random(seed)} % L2_WORDS;
        dat = $random(seed);
        sel = `HOST_SW'($random(seed));
        if (!known[idx]) begin
          sel = '1;
          known[idx] = 1'b1;
          written.push_back(idx);
        end
        shadow[idx] = merge_bytes(shadow[idx], dat, sel);
        bus_xfer(1'b1, AW'(`L2_BASE + idx * 4), dat, sel, rdata, err);
        assert (!err)
          else abort_run($sformatf("Mismatch at %0t: err on L2 write to word %0d", $time, idx));
      end else begin
        idx = written[{$random(seed)} % written.size()];
        bus_xfer(1'b0, AW'(`L2_BASE + idx * 4), '0, '1, rdata, err);
        assert (!err && rdata == shadow[idx])
          else abort_run($sformatf("Mismatch at %0t: L2 word %0d read %h err %b, expected %h",
                                   $time, idx, rdata, err, shadow[idx]));
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/host_stim.txt
# op addr data sel exp_rdata exp_err
# op is W or R, the rest is hex; exp_rdata is checked on reads only
W 0000 11111111 F 00000000 0
W 0004 22222222 F 00000000 0
W 0008 33333333 F 00000000 0
W 000C 44444444 F 00000000 0
W 0010 55555555 F 00000000 0
W 03FC CAFEF00D F 00000000 0
R 0000 00000000 F 11111111 0
R 0010 00000000 F 55555555 0
R 03FC 00000000 F CAFEF00D 0
W 0004 AABBCCDD 1 00000000 0
W 0008 AABBCCDD 6 00000000 0
W 000C AABBCCDD 8 00000000 0
R 0004 00000000 F 222222DD 0
R 0008 00000000 F 33BBCC33 0
R 000C 00000000 F AA444444 0
W 1010 01234567 F 00000000 0
W 1014 89ABCDEF F 00000000 0
W 1018 DEADBEEF F 00000000 0
W 101C 0BADF00D F 00000000 0
R 1018 00000000 F DEADBEEF 0
W 1004 12345678 1 00000000 0
R 1004 00000000 F 12345678 0
W 1000 FFFFFFFD F 00000000 0
R 1000 00000000 F 00000001 0
W 1000 00000003 F 00000000 0
R 1000 00000000 F 00000003 0
W 1008 5A5A5A5A F 00000000 0
R 1008 00000000 F 00000000 0
W 0400 DEADDEAD F 00000000 1
R 0000 00000000 F 11111111 0
W 2000 FFFFFFFF F 00000000 1
R 8000 00000000 F 00000000 1
R 1010 00000000 F 01234567 0

//--- sim.f
+incdir+include
hw/host_pkg.sv
hw/host_bus_router.sv
hw/l2_banks.sv
hw/host_ctrl_regs.sv
hw/host_domain.sv
sim/host_domain_checker.sv
sim/tb_host_domain.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_host_domain
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
